//--- rtl/cpuPkg.sv
package cpuPkg;

  localparam int WordWidth = 16;
  localparam int NumRegs = 8;
  localparam int ImmWidth = 6;                    // Signed immediate in IR[11:6]

  typedef logic [WordWidth-1:0] wordT;
  typedef logic [$clog2(NumRegs)-1:0] regIdxT;
  typedef logic [ImmWidth-1:0] immT;

  localparam wordT ResetVector = '0;             // First fetch address

  typedef enum logic [3:0] {
    OpAdd  = 4'h0,
    OpSub  = 4'h1,
    OpAnd  = 4'h2,
    OpOr   = 4'h3,
    OpXor  = 4'h4,
    OpAddi = 4'h5,
    OpLd   = 4'h6,
    OpSt   = 4'h7,
    OpBz   = 4'h8,
    OpJal  = 4'h9,
    OpJr   = 4'ha,
    OpHalt = 4'hb
  } opcodeT;

  typedef enum logic [2:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluXor, AluPass1, AluPass2
  } aluOpT;

  typedef enum logic {Op1Reg, Op1Pc} op1SelT;
  typedef enum logic {Op2Imm, Op2Reg} op2SelT;

  typedef enum logic [2:0] {
    BusNone, BusAluOut, BusPc, BusLr, BusMem
  } busSrcT;

  // PcAluRes lets BZ load its target while the ALU is still adding
  typedef enum logic [1:0] {PcLr, PcAluOut, PcInc, PcAluRes} pcSelT;

  typedef enum logic [2:0] {
    StFetch, StExecute, StMemAddr, StMemAccess, StWriteback, StHalted
  } cpuStateT;

  typedef struct packed {
    aluOpT  aluOp;
    op1SelT op1Sel;
    op2SelT op2Sel;
    busSrcT busSrc;
    pcSelT  pcSel;
    logic   pcWe;
    logic   irWe;
    logic   regWe;
    logic   lrWe;
    logic   marWe;
    logic   addrFromMar;                         // Memory address from MAR, else PC
    logic   memWe;
    logic   memRe;
  } ctrlT;

endpackage

//--- rtl/regBlock.sv
`timescale 1ns/1ps

module regBlock
  import cpuPkg::*;
(
  input  logic   Clock,
  input  logic   nReset,
  input  regIdxT Rs1,
  input  regIdxT Rs2,
  input  regIdxT Rd,
  input  logic   We,
  input  wordT   WData,
  output wordT   Rd1,
  output wordT   Rd2
);

  wordT Regs [NumRegs];

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      for (int i = 0; i < NumRegs; i++) begin
        Regs[i] <= '0;
      end
    end else if (We) begin
      Regs[Rd] <= WData;                         // R0 is writable like the rest
    end
  end

  // Both read ports are combinational
  assign Rd1 = Regs[Rs1];
  assign Rd2 = Regs[Rs2];

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu
  import cpuPkg::*;
(
  input  wordT  Op1,
  input  wordT  Op2,
  input  aluOpT AluOp,
  output wordT  Result,
  output logic  Zflag
);

  always_comb begin
    case (AluOp)
      AluAdd: begin
        Result = Op1 + Op2;
      end
      AluSub: begin
        Result = Op1 - Op2;
      end
      AluAnd: begin
        Result = Op1 & Op2;
      end
      AluOr: begin
        Result = Op1 | Op2;
      end
      AluXor: begin
        Result = Op1 ^ Op2;
      end
      AluPass1: begin
        Result = Op1;                            // BZ test and ST address
      end
      AluPass2: begin
        Result = Op2;                            // ST data
      end
      default: begin
        Result = '0;
      end
    endcase
  end

  assign Zflag = (Result == '0);

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ps

module datapath
  import cpuPkg::*;
(
  input  logic   Clock,
  input  logic   nReset,
  input  ctrlT   Ctrl,
  input  wordT   MemRData,
  output wordT   MemAddr,
  output wordT   MemWData,
  output opcodeT Opcode,
  output logic   Zflag
);

  wordT Pc;
  wordT Lr;
  wordT Ir;
  wordT Mar;
  wordT AluOut;                                  // ALU output register
  wordT AluRes;
  wordT Rd1;
  wordT Rd2;
  wordT Op1;
  wordT Op2;
  wordT SignExt;
  wordT SysBus;
  immT  Imm;

  regBlock regBlock_i (
    .Clock (Clock),
    .nReset(nReset),
    .Rs1   (Ir[5:3]),
    .Rs2   (Ir[8:6]),
    .Rd    (Ir[2:0]),
    .We    (Ctrl.regWe),
    .WData (SysBus),
    .Rd1   (Rd1),
    .Rd2   (Rd2)
  );

  alu alu_i (
    .Op1   (Op1),
    .Op2   (Op2),
    .AluOp (Ctrl.aluOp),
    .Result(AluRes),
    .Zflag (Zflag)
  );

  assign Imm = Ir[11:6];
  assign SignExt = {{(WordWidth-ImmWidth){Imm[ImmWidth-1]}}, Imm};

  // Operand selection
  assign Op1 = (Ctrl.op1Sel == Op1Pc) ? Pc : Rd1;
  assign Op2 = (Ctrl.op2Sel == Op2Reg) ? Rd2 : SignExt;

  always_comb begin
    case (Ctrl.busSrc)                           // One driver per cycle
      BusAluOut: SysBus = AluOut;
      BusPc:     SysBus = Pc;
      BusLr:     SysBus = Lr;
      BusMem:    SysBus = MemRData;
      default:   SysBus = '0;
    endcase
  end

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      Pc <= ResetVector;
    end else if (Ctrl.pcWe) begin
      case (Ctrl.pcSel)
        PcLr:     Pc <= Lr;                      // JR
        PcAluOut: Pc <= AluOut;                  // JAL target
        PcAluRes: Pc <= AluRes;                  // BZ target
        default:  Pc <= Pc + wordT'(1);
      endcase
    end
  end

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      Ir <= '0;
    end else if (Ctrl.irWe) begin
      Ir <= SysBus;
    end
  end

  always_ff @(posedge Clock) begin
    AluOut <= AluRes;                            // Loads every cycle
    if (Ctrl.lrWe) begin
      Lr <= SysBus;
    end
    if (Ctrl.marWe) begin
      Mar <= SysBus;
    end
  end

  assign MemAddr = Ctrl.addrFromMar ? Mar : Pc;
  assign MemWData = AluOut;
  assign Opcode = opcodeT'(Ir[15:12]);

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
  import cpuPkg::*;
(
  input  logic   Clock,
  input  logic   nReset,
  input  opcodeT Opcode,
  input  logic   Zflag,
  output ctrlT   Ctrl,
  output logic   Halted
);

  cpuStateT State;
  cpuStateT NextState;
  logic     Running;                             // Low for the first cycle out of reset
  logic     BzTaken;                             // rs1 was zero in BZ EXECUTE

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      State <= StFetch;
      Running <= 1'b0;
      BzTaken <= 1'b0;
    end else begin
      State <= NextState;
      Running <= 1'b1;
      if (State == StExecute && Opcode == OpBz) begin
        BzTaken <= Zflag;
      end
    end
  end

  always_comb begin
    Ctrl.aluOp = AluAdd;
    Ctrl.op1Sel = Op1Reg;
    Ctrl.op2Sel = Op2Reg;
    Ctrl.busSrc = BusNone;
    Ctrl.pcSel = PcInc;
    Ctrl.pcWe = 1'b0;
    Ctrl.irWe = 1'b0;
    Ctrl.regWe = 1'b0;
    Ctrl.lrWe = 1'b0;
    Ctrl.marWe = 1'b0;
    Ctrl.addrFromMar = 1'b0;
    Ctrl.memWe = 1'b0;
    Ctrl.memRe = 1'b0;
    NextState = State;

    case (State)
      StFetch: begin
        if (Running) begin
          Ctrl.memRe = 1'b1;                     // IR from memory at PC
          Ctrl.busSrc = BusMem;
          Ctrl.irWe = 1'b1;
          Ctrl.pcWe = 1'b1;
          NextState = StExecute;
        end
      end
      StExecute: begin
        NextState = StWriteback;
        case (Opcode)
          OpAdd: Ctrl.aluOp = AluAdd;
          OpSub: Ctrl.aluOp = AluSub;
          OpAnd: Ctrl.aluOp = AluAnd;
          OpOr:  Ctrl.aluOp = AluOr;
          OpXor: Ctrl.aluOp = AluXor;
          OpAddi: Ctrl.op2Sel = Op2Imm;
          OpLd: begin
            Ctrl.op2Sel = Op2Imm;                // rs1 plus offset
            NextState = StMemAddr;
          end
          OpSt: begin
            Ctrl.aluOp = AluPass1;               // Address is rs1
            NextState = StMemAddr;
          end
          OpBz: Ctrl.aluOp = AluPass1;           // Zflag shows rs1 == 0
          OpJal: begin
            Ctrl.op1Sel = Op1Pc;
            Ctrl.op2Sel = Op2Imm;
            Ctrl.busSrc = BusPc;                 // Return address into LR
            Ctrl.lrWe = 1'b1;
          end
          OpJr: begin
            Ctrl.pcSel = PcLr;
            Ctrl.pcWe = 1'b1;
            NextState = StFetch;
          end
          OpHalt: NextState = StHalted;
          default: NextState = StFetch;          // Unused opcodes act as NOP
        endcase
      end
      StMemAddr: begin
        Ctrl.busSrc = BusAluOut;
        Ctrl.marWe = 1'b1;
        if (Opcode == OpSt) begin
          Ctrl.aluOp = AluPass2;                 // rs2 lands in AluOut for the write
        end
        NextState = StMemAccess;
      end
      StMemAccess: begin
        Ctrl.addrFromMar = 1'b1;
        if (Opcode == OpLd) begin
          Ctrl.memRe = 1'b1;
          Ctrl.busSrc = BusMem;
          Ctrl.regWe = 1'b1;
        end else begin
          Ctrl.memWe = 1'b1;
        end
        NextState = StFetch;
      end
      StWriteback: begin
        case (Opcode)
          OpBz: begin
            Ctrl.op1Sel = Op1Pc;
            Ctrl.op2Sel = Op2Imm;
            Ctrl.pcSel = PcAluRes;
            Ctrl.pcWe = BzTaken;
          end
          OpJal: begin
            Ctrl.pcSel = PcAluOut;
            Ctrl.pcWe = 1'b1;
          end
          default: begin
            Ctrl.busSrc = BusAluOut;             // Result into rd
            Ctrl.regWe = 1'b1;
          end
        endcase
        NextState = StFetch;
      end
      StHalted: NextState = StHalted;            // Only reset leaves
      default: NextState = StFetch;
    endcase
  end

  assign Halted = (State == StHalted);

endmodule

//--- rtl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop
  import cpuPkg::*;
(
  input  logic Clock,
  input  logic nReset,
  input  wordT MemRData,
  output wordT MemAddr,
  output wordT MemWData,
  output logic MemWe,
  output logic MemRe,
  output logic Halted
);

  ctrlT   Ctrl;
  opcodeT Opcode;
  logic   Zflag;

  controlUnit controlUnit_i (
    .Clock (Clock),
    .nReset(nReset),
    .Opcode(Opcode),
    .Zflag (Zflag),
    .Ctrl  (Ctrl),
    .Halted(Halted)
  );

  datapath datapath_i (
    .Clock   (Clock),
    .nReset  (nReset),
    .Ctrl    (Ctrl),
    .MemRData(MemRData),
    .MemAddr (MemAddr),
    .MemWData(MemWData),
    .Opcode  (Opcode),
    .Zflag   (Zflag)
  );

  // Strobes straight from the control word
  assign MemWe = Ctrl.memWe;
  assign MemRe = Ctrl.memRe;

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic Clock,
  output logic nReset
);

  initial begin
    Clock = 1'b0;
    forever #50 Clock = ~Clock;                  // 100 ns period
  end

  initial begin
    nReset = 1'b0;
    repeat (2) @(posedge Clock);
    @(negedge Clock);
    nReset = 1'b1;                               // Released on a falling edge
  end

endmodule

//--- tb/cpuTb.sv
`timescale 1ns/1ps

module cpuTb
  import cpuPkg::*;
();

  localparam int WatchdogCycles = 20000;         // Ten times the longest program
  localparam int HaltLimit = 2000;

  logic       Clock;
  logic       nPowerOnReset;
  logic       nTestReset;
  logic       nReset;
  wordT       MemRData;
  wordT       MemAddr;
  wordT       MemWData;
  logic       MemWe;
  logic       MemRe;
  logic       Halted;
  wordT       Mem [256];
  wordT       ModelMem [256];
  logic [7:0] DutLog [$];                        // Store addresses in order
  logic [7:0] ModelLog [$];
  int         DutReads;                          // Cycles with MemRe high
  int         ModelReads;                        // Fetches plus loads
  logic [7:0] ProgPtr;
  integer     Seed;
  int         ErrorCount;

  assign nReset = nPowerOnReset & nTestReset;
  assign MemRData = Mem[MemAddr[7:0]];           // Low 8 address bits pick the word

  clockGen clockGen_i (
    .Clock (Clock),
    .nReset(nPowerOnReset)
  );

  cpuTop cpuTop_i (
    .Clock   (Clock),
    .nReset  (nReset),
    .MemRData(MemRData),
    .MemAddr (MemAddr),
    .MemWData(MemWData),
    .MemWe   (MemWe),
    .MemRe   (MemRe),
    .Halted  (Halted)
  );

  function automatic wordT rType(opcodeT op, regIdxT rd, regIdxT rs1, regIdxT rs2);
    return {op, 3'b000, rs2, rs1, rd};
  endfunction

  function automatic wordT iType(opcodeT op, regIdxT rd, regIdxT rs1, immT imm);
    return {op, imm, rs1, rd};
  endfunction

  task automatic emit(input wordT instr);
    Mem[ProgPtr] = instr;
    ProgPtr = ProgPtr + 8'd1;
  endtask

  task automatic fillMemory();
    for (int i = 0; i < 256; i++) begin
      Mem[i] = {8'(i), ~8'(i)};
    end
    ProgPtr = '0;
  endtask

  task automatic clearMemory();
    @(negedge Clock);
    nTestReset = 1'b0;
    fillMemory();
  endtask

  task automatic releaseReset();
    @(negedge Clock);
    DutLog.delete();
    DutReads = 0;
    nTestReset = 1'b1;
  endtask

  task automatic startRun();
    ModelMem = Mem;                              // Model starts from the loaded image
    releaseReset();
  endtask

  // One pass per clock, entered and left on a falling edge
  task automatic runCycles(input int maxCycles, output int cycles);
    logic       we;
    logic       re;
    logic [7:0] addr;
    wordT       data;
    cycles = 0;
    while (!Halted && cycles < maxCycles) begin
      we = MemWe;
      re = MemRe;
      addr = MemAddr[7:0];
      data = MemWData;
      @(posedge Clock);
      if (we) begin
        Mem[addr] = data;
        DutLog.push_back(addr);
      end
      if (re) begin
        DutReads++;
      end
      @(negedge Clock);
      cycles++;
    end
  endtask

  task automatic runToHalt(input string name);
    int cycles;
    runCycles(HaltLimit, cycles);
    if (!Halted) begin
      $display("%s: processor did not halt within %0d cycles", name, HaltLimit);
      ErrorCount++;
    end
  endtask

  // Instruction level model of the ISA
  task automatic runModel();
    wordT regs [8];
    wordT pc;
    wordT lr;
    wordT ir;
    wordT imm;
    wordT a;
    wordT b;
    wordT addr;
    int   steps;
    logic done;
    for (int i = 0; i < 8; i++) begin
      regs[i] = '0;
    end
    pc = ResetVector;
    lr = '0;
    done = 1'b0;
    steps = 0;
    ModelReads = 0;
    ModelLog.delete();
    while (!done && steps < HaltLimit) begin
      ir = ModelMem[pc[7:0]];
      ModelReads++;
      pc = pc + 16'd1;                           // PC points past the instruction
      imm = {{10{ir[11]}}, ir[11:6]};
      a = regs[ir[5:3]];
      b = regs[ir[8:6]];
      addr = a + imm;
      case (opcodeT'(ir[15:12]))
        OpAdd:  regs[ir[2:0]] = a + b;
        OpSub:  regs[ir[2:0]] = a - b;
        OpAnd:  regs[ir[2:0]] = a & b;
        OpOr:   regs[ir[2:0]] = a | b;
        OpXor:  regs[ir[2:0]] = a ^ b;
        OpAddi: regs[ir[2:0]] = addr;
        OpLd: begin
          regs[ir[2:0]] = ModelMem[addr[7:0]];
          ModelReads++;
        end
        OpSt: begin
          ModelMem[a[7:0]] = b;
          ModelLog.push_back(a[7:0]);
        end
        OpBz: begin
          if (a == '0) begin
            pc = pc + imm;
          end
        end
        OpJal: begin
          lr = pc;
          pc = pc + imm;
        end
        OpJr:   pc = lr;
        OpHalt: done = 1'b1;
        default: ;
      endcase
      steps++;
    end
  endtask

  task automatic checkMemory(input string name);
    runModel();
    for (int i = 0; i < 256; i++) begin
      if (Mem[i] !== ModelMem[i]) begin
        $display("FAIL %s: word %0h expected %h actual %h", name, i, ModelMem[i], Mem[i]);
        ErrorCount++;
      end
    end
    if (DutReads != ModelReads) begin
      $display("FAIL %s: read strobes expected %0d actual %0d", name,
               ModelReads, DutReads);
      ErrorCount++;
    end
    if (DutLog.size() != ModelLog.size()) begin
      $display("FAIL %s: store count expected %0d actual %0d", name,
               ModelLog.size(), DutLog.size());
      ErrorCount++;
    end else begin
      for (int i = 0; i < DutLog.size(); i++) begin
        if (DutLog[i] !== ModelLog[i]) begin
          $display("FAIL %s: store %0d address expected %h actual %h", name, i,
                   ModelLog[i], DutLog[i]);
          ErrorCount++;
        end
      end
    end
  endtask

  task automatic storeAndAdvance(input regIdxT ptr, input regIdxT data);
    emit(rType(OpSt, 3'd0, ptr, data));
    emit(iType(OpAddi, ptr, ptr, 6'h01));
  endtask

  // Two rounds of operands from 0xe0 up, results stored from 0xf0 up
  task automatic buildAluProgram();
    opcodeT ops [5] = '{OpAdd, OpSub, OpAnd, OpOr, OpXor};
    clearMemory();
    emit(iType(OpAddi, 3'd4, 3'd0, 6'h30));      // r4 = -16
    for (int round = 0; round < 2; round++) begin
      Mem[8'(224 + 2 * round)] = wordT'($random(Seed));
      Mem[8'(225 + 2 * round)] = wordT'($random(Seed));
      emit(iType(OpLd, 3'd1, 3'd0, immT'(32 + 2 * round)));
      emit(iType(OpLd, 3'd2, 3'd0, immT'(33 + 2 * round)));
      for (int k = 0; k < 5; k++) begin
        emit(rType(ops[k], 3'd3, 3'd1, 3'd2));
        storeAndAdvance(3'd4, 3'd3);
      end
      emit(iType(OpAddi, 3'd3, 3'd1, immT'($random(Seed))));
      storeAndAdvance(3'd4, 3'd3);
    end
    emit({OpHalt, 12'h000});
  endtask

  task automatic aluTest();
    buildAluProgram();
    startRun();
    runToHalt("aluTest");
    checkMemory("aluTest");
  endtask

  task automatic memTest();
    clearMemory();
    for (int i = 0; i < 8; i++) begin
      Mem[8'(220 + i)] = wordT'($random(Seed)); // Source block 0xdc to 0xe3
    end
    emit(iType(OpAddi, 3'd1, 3'd0, 6'h20));      // r1 = -32
    emit(iType(OpAddi, 3'd2, 3'd0, 6'h30));      // r2 = -16
    for (int i = 0; i < 8; i++) begin
      emit(iType(OpLd, 3'd3, 3'd1, immT'(i - 4)));
      storeAndAdvance(3'd2, 3'd3);
    end
    emit({OpHalt, 12'h000});
    startRun();
    runToHalt("memTest");
    checkMemory("memTest");
    for (int i = 0; i < 8; i++) begin
      if (Mem[8'(240 + i)] !== ModelMem[8'(220 + i)]) begin
        $display("FAIL memTest: copy %0d expected %h actual %h", i,
                 ModelMem[8'(220 + i)], Mem[8'(240 + i)]);
        ErrorCount++;
      end
    end
  endtask

  task automatic branchCase(input regIdxT test, input regIdxT ftPtr, input regIdxT takenPtr);
    emit(iType(OpBz, 3'd0, test, 6'h02));
    emit(rType(OpSt, 3'd0, ftPtr, 3'd6));        // Fall-through marker
    emit(iType(OpBz, 3'd0, 3'd0, 6'h01));        // Skip the taken marker
    emit(rType(OpSt, 3'd0, takenPtr, 3'd6));     // Taken marker
  endtask

  task automatic branchTest();
    immT nonZero;
    clearMemory();
    nonZero = immT'($random(Seed)) | 6'h01;
    emit(iType(OpAddi, 3'd1, 3'd0, nonZero));
    emit(iType(OpAddi, 3'd6, 3'd0, 6'h15));
    for (int i = 0; i < 4; i++) begin
      emit(iType(OpAddi, regIdxT'(i + 2), 3'd0, immT'(48 + i))); // Markers at 0xf0 up
    end
    branchCase(3'd0, 3'd2, 3'd3);
    branchCase(3'd1, 3'd4, 3'd5);
    emit({OpHalt, 12'h000});
    startRun();
    runToHalt("branchTest");
    checkMemory("branchTest");
  endtask

  task automatic callTest();
    clearMemory();
    emit(iType(OpAddi, 3'd2, 3'd0, 6'h30));
    emit(iType(OpAddi, 3'd3, 3'd0, 6'h31));
    emit(iType(OpAddi, 3'd6, 3'd0, immT'($random(Seed))));
    emit(iType(OpJal, 3'd0, 3'd0, 6'h03));      // Subroutine at word 7
    emit(iType(OpAddi, 3'd6, 3'd6, 6'h01));      // Return point
    emit(rType(OpSt, 3'd0, 3'd3, 3'd6));
    emit({OpHalt, 12'h000});
    emit(rType(OpSt, 3'd0, 3'd2, 3'd6));
    emit({OpJr, 12'h000});
    startRun();
    runToHalt("callTest");
    checkMemory("callTest");
  endtask

  // Entered on a falling edge with nReset just asserted
  task automatic checkResetOutputs();
    repeat (2) begin
      #10;
      if ({MemWe, MemRe, Halted} !== 3'b000) begin
        $display("FAIL resetTest: MemWe MemRe Halted expected 000 actual %b%b%b",
                 MemWe, MemRe, Halted);
        ErrorCount++;
      end
      if (MemAddr !== '0) begin
        $display("FAIL resetTest: MemAddr expected 0000 actual %h", MemAddr);
        ErrorCount++;
      end
      @(negedge Clock);
    end
  endtask

  task automatic resetTest();
    int cycles;
    buildAluProgram();
    startRun();
    runCycles(18, cycles);
    nTestReset = 1'b0;                           // Reset lands on the first store
    checkResetOutputs();
    releaseReset();
    runToHalt("resetTest");
    checkMemory("resetTest");
    nTestReset = 1'b0;                           // Reset again while halted
    checkResetOutputs();
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge Clock);
    $display("Watchdog expired after %0d cycles", WatchdogCycles);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    Seed = 32'h3ba7ffbd;
    ErrorCount = 0;
    DutReads = 0;
    ModelReads = 0;
    nTestReset = 1'b0;
    fillMemory();
    aluTest();
    memTest();
    branchTest();
    callTest();
    resetTest();
    $display("Tests done, error count %0d", ErrorCount);
    if (ErrorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
rtl/cpuPkg.sv
rtl/regBlock.sv
rtl/alu.sv
rtl/datapath.sv
rtl/controlUnit.sv
rtl/cpuTop.sv
tb/clockGen.sv
tb/cpuTb.sv

//--- Makefile
# Verilator build and run for the 16-bit multicycle processor
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
